// ==== compile.f ====
source/pe_csr_pkg.sv
source/dram_bus_pkg.sv
source/word_window.sv
source/pe_csr_regs.sv
source/dram_debug_master.sv
source/pe_host_top.sv
verif/pe_host_sva.sv
verif/pe_host_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pe_host_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vpe_host_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi

exit 0

// ==== source/dram_bus_pkg.sv ====
package dram_bus_pkg;

    localparam int LINE_BITS  = 512;
    localparam int ADDR_BITS  = 64;
    localparam int LINE_WORDS = LINE_BITS / 32; // csr words per line

    typedef logic [LINE_BITS-1:0]   dram_line_t;
    typedef logic [ADDR_BITS-1:0]   dram_addr_t;
    typedef logic [2:0]             burst_t;
    typedef logic [LINE_BITS/8-1:0] byteen_t;
    typedef logic [63:0]            counter_t;

    // fixed attributes of every debug request
    localparam burst_t  BURST_ONE    = 3'd1;
    localparam byteen_t BYTEEN_ALL   = '1;
    localparam logic    DEBUG_ACCESS = 1'b0;

endpackage

// ==== source/dram_debug_master.sv ====
`default_nettype none

module dram_debug_master (
    input  wire                      clk,
    input  wire                      reset,

    input  logic                     read_kick,
    input  logic                     write_kick,
    input  dram_bus_pkg::dram_addr_t req_address,
    input  dram_bus_pkg::dram_line_t req_line,
    output dram_bus_pkg::dram_line_t captured_line,

    input  logic                     m0_waitrequest,
    input  logic                     m0_readdatavalid,
    input  dram_bus_pkg::dram_line_t m0_readdata,
    output logic                     m0_read,
    output logic                     m0_write,
    output dram_bus_pkg::dram_addr_t m0_address,
    output dram_bus_pkg::dram_line_t m0_writedata,
    output dram_bus_pkg::burst_t     m0_burstcount,
    output dram_bus_pkg::byteen_t    m0_byteenable,
    output logic                     m0_debugaccess
);
    import dram_bus_pkg::*;

    logic read_kick_d;
    logic write_kick_d;
    logic read_start;
    logic write_start;
    logic busy;

    assign read_start  = read_kick && !read_kick_d;
    assign write_start = write_kick && !write_kick_d;
    assign busy        = m0_read || m0_write;

    assign m0_burstcount  = BURST_ONE;
    assign m0_byteenable  = BYTEEN_ALL;
    assign m0_debugaccess = DEBUG_ACCESS;

    // request strobes, held while the bus waits
    always_ff @(posedge clk) begin
        if (reset) begin
            read_kick_d  <= 1'b0;
            write_kick_d <= 1'b0;
            m0_read      <= 1'b0;
            m0_write     <= 1'b0;
        end else begin
            read_kick_d  <= read_kick;
            write_kick_d <= write_kick;

            if (write_start) begin
                m0_write <= 1'b1;
            end else if (m0_write && !m0_waitrequest) begin
                m0_write <= 1'b0; // accepted
            end

            if (read_start) begin
                m0_read <= 1'b1;
            end else if (m0_read && !m0_waitrequest) begin
                m0_read <= 1'b0;
            end
        end
    end

    // request payload frozen at the kick edge
    always_ff @(posedge clk) begin
        if (reset) begin
            m0_address   <= '0;
            m0_writedata <= '0;
        end else if ((read_start || write_start) && !busy) begin
            m0_address   <= req_address;
            m0_writedata <= req_line;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            captured_line <= '1;
        end else if (m0_readdatavalid) begin
            captured_line <= m0_readdata;
        end
    end

endmodule

`default_nettype wire

// ==== source/pe_csr_pkg.sv ====
package pe_csr_pkg;

    typedef logic [4:0]  csr_addr_t;
    typedef logic [31:0] csr_word_t;

    // register map, word addresses
    localparam csr_addr_t ADDR_VERSION       = 5'd0;
    localparam csr_addr_t ADDR_CONTROL       = 5'd3;
    localparam csr_addr_t ADDR_RECV_COUNT_HI = 5'd4;
    localparam csr_addr_t ADDR_RECV_COUNT_LO = 5'd5;
    localparam csr_addr_t ADDR_SRC_COUNT_HI  = 5'd6;
    localparam csr_addr_t ADDR_SRC_COUNT_LO  = 5'd7;
    localparam csr_addr_t ADDR_KICK          = 5'd13;
    localparam csr_addr_t ADDR_DRAM_ADDR_HI  = 5'd14;
    localparam csr_addr_t ADDR_DRAM_ADDR_LO  = 5'd15;
    localparam csr_addr_t ADDR_LINE_FIRST    = 5'd16; // line words run up to 31

    localparam csr_word_t VERSION       = 32'h3434_0002;
    localparam csr_word_t UNMAPPED_WORD = 32'hDEAD_BEEF;

    // control register bits
    localparam int CTRL_RECV_KICK  = 2;
    localparam int CTRL_RECV_CLEAR = 1;
    localparam int CTRL_SRC_CLEAR  = 0;

    // kick register bits
    localparam int KICK_READ  = 1;
    localparam int KICK_WRITE = 0;

endpackage

// ==== source/pe_csr_regs.sv ====
`default_nettype none

module pe_csr_regs (
    input  wire                     clk,
    input  wire                     reset,

    input  pe_csr_pkg::csr_addr_t   csr_address,
    input  pe_csr_pkg::csr_word_t   csr_writedata,
    input  logic                    csr_write,
    input  logic                    csr_read,
    output pe_csr_pkg::csr_word_t   csr_readdata,

    input  dram_bus_pkg::counter_t  recv_fifo_counter,
    input  dram_bus_pkg::counter_t  src_counter,
    input  dram_bus_pkg::dram_line_t captured_line,

    output logic                    recv_fifo_kick,
    output logic                    recv_fifo_clear,
    output logic                    src_clear,
    output logic                    read_kick,
    output logic                    write_kick,

    output dram_bus_pkg::dram_addr_t req_address,
    output dram_bus_pkg::dram_line_t req_line
);
    import pe_csr_pkg::*;
    import dram_bus_pkg::*;

    localparam int WORD_BITS = $bits(csr_word_t);

    logic       addr_hit;
    logic       line_hit;
    logic [3:0] addr_index;
    logic [3:0] line_index;
    csr_word_t  control_word;
    csr_word_t  line_word;

    assign addr_hit   = (csr_address == ADDR_DRAM_ADDR_HI) || (csr_address == ADDR_DRAM_ADDR_LO);
    assign line_hit   = csr_address >= ADDR_LINE_FIRST;
    assign addr_index = (csr_address == ADDR_DRAM_ADDR_LO) ? 4'd1 : 4'd0; // hi word first
    assign line_index = 4'(csr_address - ADDR_LINE_FIRST);

    word_window #(
        .payload_t (dram_addr_t)
    ) address_window (
        .clk        (clk),
        .reset      (reset),
        .word_we    (csr_write && addr_hit),
        .word_index (addr_index),
        .word_data  (csr_writedata),
        .value      (req_address)
    );

    word_window #(
        .payload_t (dram_line_t)
    ) line_window (
        .clk        (clk),
        .reset      (reset),
        .word_we    (csr_write && line_hit),
        .word_index (line_index),
        .word_data  (csr_writedata),
        .value      (req_line)
    );

    // control and kick registers
    always_ff @(posedge clk) begin
        if (reset) begin
            recv_fifo_kick  <= 1'b0;
            recv_fifo_clear <= 1'b0;
            src_clear       <= 1'b0;
            read_kick       <= 1'b0;
            write_kick      <= 1'b0;
        end else if (csr_write) begin
            case (csr_address)
                ADDR_CONTROL: begin
                    recv_fifo_kick  <= csr_writedata[CTRL_RECV_KICK];
                    recv_fifo_clear <= csr_writedata[CTRL_RECV_CLEAR];
                    src_clear       <= csr_writedata[CTRL_SRC_CLEAR];
                end
                ADDR_KICK: begin
                    read_kick  <= csr_writedata[KICK_READ];
                    write_kick <= csr_writedata[KICK_WRITE];
                end
                ADDR_DRAM_ADDR_HI, ADDR_DRAM_ADDR_LO: ; // taken by address_window
                default: begin
                    if (!line_hit) begin // unmapped write drops both kicks
                        read_kick  <= 1'b0;
                        write_kick <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_comb begin
        control_word                  = '0;
        control_word[CTRL_RECV_KICK]  = recv_fifo_kick;
        control_word[CTRL_RECV_CLEAR] = recv_fifo_clear;
        control_word[CTRL_SRC_CLEAR]  = src_clear;
    end

    // word 0 of the line is the top word
    assign line_word =
        captured_line[(LINE_WORDS - 1 - int'(line_index)) * WORD_BITS +: WORD_BITS];

    // readback, one cycle after the read strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            csr_readdata <= '0;
        end else if (csr_read) begin
            case (csr_address)
                ADDR_VERSION:       csr_readdata <= VERSION;
                ADDR_CONTROL:       csr_readdata <= control_word;
                ADDR_RECV_COUNT_HI: csr_readdata <= recv_fifo_counter[63:32];
                ADDR_RECV_COUNT_LO: csr_readdata <= recv_fifo_counter[31:0];
                ADDR_SRC_COUNT_HI:  csr_readdata <= src_counter[63:32];
                ADDR_SRC_COUNT_LO:  csr_readdata <= src_counter[31:0];
                default: begin
                    if (line_hit) begin
                        csr_readdata <= line_word;
                    end else begin
                        csr_readdata <= UNMAPPED_WORD;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/pe_host_top.sv ====
`default_nettype none

module pe_host_top (
    input  wire                      clk,
    input  wire                      reset,

    input  pe_csr_pkg::csr_addr_t    csr_address,
    input  pe_csr_pkg::csr_word_t    csr_writedata,
    input  logic                     csr_write,
    input  logic                     csr_read,
    output pe_csr_pkg::csr_word_t    csr_readdata,

    input  logic                     m0_waitrequest,
    input  logic                     m0_readdatavalid,
    input  dram_bus_pkg::dram_line_t m0_readdata,
    output logic                     m0_read,
    output logic                     m0_write,
    output dram_bus_pkg::dram_addr_t m0_address,
    output dram_bus_pkg::dram_line_t m0_writedata,
    output dram_bus_pkg::burst_t     m0_burstcount,
    output dram_bus_pkg::byteen_t    m0_byteenable,
    output logic                     m0_debugaccess,

    output logic                     recv_fifo_kick,
    output logic                     recv_fifo_clear,
    output logic                     src_clear,
    input  dram_bus_pkg::counter_t   recv_fifo_counter,
    input  dram_bus_pkg::counter_t   src_counter
);
    import dram_bus_pkg::*;

    logic       read_kick;
    logic       write_kick;
    dram_addr_t req_address;
    dram_line_t req_line;
    dram_line_t captured_line;

    pe_csr_regs csr_regs (
        .clk               (clk),
        .reset             (reset),
        .csr_address       (csr_address),
        .csr_writedata     (csr_writedata),
        .csr_write         (csr_write),
        .csr_read          (csr_read),
        .csr_readdata      (csr_readdata),
        .recv_fifo_counter (recv_fifo_counter),
        .src_counter       (src_counter),
        .captured_line     (captured_line),
        .recv_fifo_kick    (recv_fifo_kick),
        .recv_fifo_clear   (recv_fifo_clear),
        .src_clear         (src_clear),
        .read_kick         (read_kick),
        .write_kick        (write_kick),
        .req_address       (req_address),
        .req_line          (req_line)
    );

    // m0 debug port, steered by the kick levels
    dram_debug_master debug_master (
        .clk              (clk),
        .reset            (reset),
        .read_kick        (read_kick),
        .write_kick       (write_kick),
        .req_address      (req_address),
        .req_line         (req_line),
        .captured_line    (captured_line),
        .m0_waitrequest   (m0_waitrequest),
        .m0_readdatavalid (m0_readdatavalid),
        .m0_readdata      (m0_readdata),
        .m0_read          (m0_read),
        .m0_write         (m0_write),
        .m0_address       (m0_address),
        .m0_writedata     (m0_writedata),
        .m0_burstcount    (m0_burstcount),
        .m0_byteenable    (m0_byteenable),
        .m0_debugaccess   (m0_debugaccess)
    );

endmodule

`default_nettype wire

// ==== source/word_window.sv ====
`default_nettype none

module word_window #(
    parameter type payload_t = logic [63:0]
) (
    input  wire                   clk,
    input  wire                   reset,
    input  logic                  word_we,
    input  logic [3:0]            word_index,
    input  pe_csr_pkg::csr_word_t word_data,
    output payload_t              value
);
    import pe_csr_pkg::*;

    localparam int WORD_BITS = $bits(csr_word_t);
    localparam int WORDS     = $bits(payload_t) / WORD_BITS;

    logic index_ok;

    assign index_ok = int'(word_index) < WORDS; // ignore words past the payload

    // index 0 lands in the most significant word
    always_ff @(posedge clk) begin
        if (reset) begin
            value <= '0;
        end else if (word_we && index_ok) begin
            value[(WORDS - 1 - int'(word_index)) * WORD_BITS +: WORD_BITS] <= word_data;
        end
    end

endmodule

`default_nettype wire

// ==== verif/pe_host_sva.sv ====
module pe_host_sva (
    input logic                     clk,
    input logic                     reset,
    input logic                     m0_read,
    input logic                     m0_write,
    input logic                     m0_waitrequest,
    input dram_bus_pkg::dram_addr_t m0_address,
    input dram_bus_pkg::dram_line_t m0_writedata
);
    timeunit 1ns;
    timeprecision 1ps;

    // stalled request keeps strobe and payload
    write_held: assert property (@(posedge clk) disable iff (reset)
        m0_write && m0_waitrequest |=> m0_write && $stable(m0_address) && $stable(m0_writedata))
        else $error("m0 write changed while waitrequest was high");

    read_held: assert property (@(posedge clk) disable iff (reset)
        m0_read && m0_waitrequest |=> m0_read && $stable(m0_address))
        else $error("m0 read changed while waitrequest was high");

    idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !m0_read && !m0_write)
        else $error("m0 request active in the cycle after reset");

endmodule

bind dram_debug_master pe_host_sva m0_checks (
    .clk            (clk),
    .reset          (reset),
    .m0_read        (m0_read),
    .m0_write       (m0_write),
    .m0_waitrequest (m0_waitrequest),
    .m0_address     (m0_address),
    .m0_writedata   (m0_writedata)
);

// ==== verif/pe_host_tb.sv ====
module pe_host_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import pe_csr_pkg::*;
    import dram_bus_pkg::*;

    logic       clk;
    logic       reset;
    csr_addr_t  csr_address;
    csr_word_t  csr_writedata;
    logic       csr_write;
    logic       csr_read;
    csr_word_t  csr_readdata;

    logic       m0_waitrequest   = 1'b0;
    logic       m0_readdatavalid = 1'b0;
    dram_line_t m0_readdata      = '0;
    logic       m0_read;
    logic       m0_write;
    dram_addr_t m0_address;
    dram_line_t m0_writedata;
    burst_t     m0_burstcount;
    byteen_t    m0_byteenable;
    logic       m0_debugaccess;

    logic       recv_fifo_kick;
    logic       recv_fifo_clear;
    logic       src_clear;
    counter_t   recv_fifo_counter;
    counter_t   src_counter;

    // dram model state
    integer     seed = 32'hb595_6648;
    dram_addr_t wr_addrs[$];
    dram_line_t wr_lines[$];
    burst_t     wr_burst;
    byteen_t    wr_byteen;
    logic       wr_debug;
    dram_addr_t rd_addr;
    int         rd_accepts;
    int         rd_returns;
    int         rd_wait;
    int         next_delay = 1;

    int errors;
    int tests_run;
    int tests_failed;

    pe_host_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory contents seen by a read
    function automatic dram_line_t line_pattern(input dram_addr_t addr);
        dram_line_t line;
        int i;
        line = '0;
        for (i = 0; i < LINE_WORDS; i++) begin
            line[i * 32 +: 32] = (addr[31:0] ^ {addr[47:32], addr[63:48]}) + 32'(i) * 32'h0101_0101;
        end
        return line;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            rd_wait = 0;
        end else begin
            if (m0_write && !m0_waitrequest) begin
                wr_addrs.push_back(m0_address);
                wr_lines.push_back(m0_writedata);
                wr_burst  = m0_burstcount;
                wr_byteen = m0_byteenable;
                wr_debug  = m0_debugaccess;
            end
            if (m0_readdatavalid) begin
                rd_returns++;
            end
            if (rd_wait > 0) begin
                rd_wait--;
            end
            if (m0_read && !m0_waitrequest) begin
                rd_addr = m0_address;
                rd_accepts++;
                rd_wait = next_delay; // 1 to 6 cycles
            end
        end
    end

    always @(negedge clk) begin : drive_dram
        logic [31:0] rnd;
        rnd = $random(seed);
        m0_waitrequest = rnd[0];
        next_delay = 1 + int'(rnd[15:8] % 8'd6);
        if (rd_wait == 1) begin
            m0_readdatavalid = 1'b1;
            m0_readdata      = line_pattern(rd_addr);
        end else begin
            m0_readdatavalid = 1'b0;
        end
    end

    task automatic csr_wr(input csr_addr_t addr, input csr_word_t data);
        csr_address   = addr;
        csr_writedata = data;
        csr_write     = 1'b1;
        @(negedge clk);
        csr_write = 1'b0;
    endtask

    task automatic csr_rd(input csr_addr_t addr, output csr_word_t data);
        csr_address = addr;
        csr_read    = 1'b1;
        @(negedge clk);
        csr_read = 1'b0;
        data     = csr_readdata; // registered on the edge just passed
    endtask

    task automatic report_mismatch(input string test, input dram_line_t expected,
                                   input dram_line_t actual);
        $display("Error %s: expected %0h, actual %0h", test, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string test, input string what);
        $display("%s: %s", test, what);
        errors++;
    endtask

    task automatic finish_test(input string test, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", test);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test, errors - errors_before);
        end
    endtask

    task automatic wait_write_count(input string test, input int target);
        int cycles;
        cycles = 0;
        while (wr_addrs.size() < target && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (wr_addrs.size() < target) begin
            report_failure(test, "timed out waiting for a DRAM write");
        end
    endtask

    task automatic wait_read_returns(input string test, input int target);
        int cycles;
        cycles = 0;
        while (rd_returns < target && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (rd_returns < target) begin
            report_failure(test, "timed out waiting for DRAM read data");
        end
    endtask

    task automatic load_address(input dram_addr_t addr);
        csr_wr(ADDR_DRAM_ADDR_HI, addr[63:32]);
        csr_wr(ADDR_DRAM_ADDR_LO, addr[31:0]);
    endtask

    task automatic test_version_and_unmapped;
        csr_word_t got;
        csr_addr_t unmapped[3];
        int first_error;
        int i;
        first_error = errors;
        unmapped = '{5'd1, 5'd2, 5'd9};
        csr_rd(ADDR_VERSION, got);
        if (got !== 32'h3434_0002) begin
            report_mismatch("version_and_unmapped", dram_line_t'(32'h3434_0002), dram_line_t'(got));
        end
        for (i = 0; i < 3; i++) begin
            csr_rd(unmapped[i], got);
            if (got !== 32'hdead_beef) begin
                report_mismatch("version_and_unmapped", dram_line_t'(32'hdead_beef),
                                dram_line_t'(got));
            end
        end
        finish_test("version_and_unmapped", first_error);
    endtask

    task automatic test_control_and_counters;
        csr_word_t got;
        csr_word_t halves[4];
        int first_error;
        int i;
        first_error = errors;
        recv_fifo_counter = 64'h0123_4567_89ab_cdef;
        src_counter       = 64'hfedc_ba98_7654_3210;
        halves = '{32'h0123_4567, 32'h89ab_cdef, 32'hfedc_ba98, 32'h7654_3210};
        csr_wr(ADDR_CONTROL, 32'h0000_000d); // bit 3 has no register
        if ({recv_fifo_kick, recv_fifo_clear, src_clear} !== 3'b101) begin
            report_mismatch("control_and_counters", dram_line_t'(3'b101),
                            dram_line_t'({recv_fifo_kick, recv_fifo_clear, src_clear}));
        end
        csr_rd(ADDR_CONTROL, got);
        if (got !== 32'h0000_0005) begin
            report_mismatch("control_and_counters", dram_line_t'(32'h5), dram_line_t'(got));
        end
        csr_wr(ADDR_CONTROL, 32'h0000_0002);
        if ({recv_fifo_kick, recv_fifo_clear, src_clear} !== 3'b010) begin
            report_mismatch("control_and_counters", dram_line_t'(3'b010),
                            dram_line_t'({recv_fifo_kick, recv_fifo_clear, src_clear}));
        end
        for (i = 0; i < 4; i++) begin
            csr_rd(csr_addr_t'(4 + i), got);
            if (got !== halves[i]) begin
                report_mismatch("control_and_counters", dram_line_t'(halves[i]), dram_line_t'(got));
            end
        end
        finish_test("control_and_counters", first_error);
    endtask

    task automatic test_dram_write;
        dram_addr_t addr;
        dram_line_t line;
        int first_error;
        int first_write;
        int i;
        first_error = errors;
        first_write = wr_addrs.size();
        addr = 64'h0000_0012_3456_7840;
        for (i = 0; i < LINE_WORDS; i++) begin
            line[(LINE_WORDS - 1 - i) * 32 +: 32] = 32'hc0de_0000 + 32'(i * 257);
        end
        load_address(addr);
        for (i = 0; i < LINE_WORDS; i++) begin
            csr_wr(csr_addr_t'(16 + i), line[(LINE_WORDS - 1 - i) * 32 +: 32]); // top word first
        end
        csr_wr(ADDR_KICK, 32'h0000_0001);
        wait_write_count("dram_write", first_write + 1);
        repeat (10) @(negedge clk);
        if (wr_addrs.size() != first_write + 1) begin
            report_failure("dram_write", "the kick did not give exactly one DRAM write");
        end else begin
            if (wr_addrs[first_write] !== addr) begin
                report_mismatch("dram_write", dram_line_t'(addr), dram_line_t'(wr_addrs[first_write]));
            end
            if (wr_lines[first_write] !== line) begin
                report_mismatch("dram_write", line, wr_lines[first_write]);
            end
            if (wr_burst !== 3'd1) begin
                report_mismatch("dram_write", dram_line_t'(3'd1), dram_line_t'(wr_burst));
            end
            if (wr_byteen !== {64{1'b1}}) begin
                report_mismatch("dram_write", dram_line_t'({64{1'b1}}), dram_line_t'(wr_byteen));
            end
            if (wr_debug !== DEBUG_ACCESS) begin
                report_mismatch("dram_write", dram_line_t'(DEBUG_ACCESS), dram_line_t'(wr_debug));
            end
        end
        finish_test("dram_write", first_error);
    endtask

    task automatic test_dram_read;
        dram_addr_t addr;
        dram_line_t expected;
        csr_word_t got;
        int first_error;
        int i;
        first_error = errors;
        addr = 64'h0000_00ab_cdef_0100;
        csr_wr(ADDR_KICK, 32'h0000_0000);
        load_address(addr);
        csr_wr(ADDR_KICK, 32'h0000_0002);
        wait_read_returns("dram_read", rd_returns + 1);
        if (rd_addr !== addr) begin
            report_mismatch("dram_read", dram_line_t'(addr), dram_line_t'(rd_addr));
        end
        expected = line_pattern(addr);
        for (i = 0; i < LINE_WORDS; i++) begin
            csr_rd(csr_addr_t'(16 + i), got);
            if (got !== expected[(LINE_WORDS - 1 - i) * 32 +: 32]) begin
                report_mismatch("dram_read", dram_line_t'(expected[(LINE_WORDS - 1 - i) * 32 +: 32]),
                                dram_line_t'(got));
            end
        end
        finish_test("dram_read", first_error);
    endtask

    task automatic test_rekick;
        dram_addr_t addr;
        dram_line_t expected;
        csr_word_t got;
        logic saw_read;
        int first_error;
        int first_read;
        first_error = errors;
        first_read = rd_accepts;
        saw_read = 1'b0;
        csr_wr(ADDR_KICK, 32'h0000_0002); // read kick is still set
        repeat (10) begin
            @(negedge clk);
            saw_read = saw_read | m0_read;
        end
        if (saw_read || rd_accepts != first_read) begin
            report_failure("rekick", "a kick written again without clearing started a request");
        end
        addr = 64'h0000_0007_0000_2040;
        csr_wr(5'd9, 32'h0000_0000);
        load_address(addr);
        csr_wr(ADDR_KICK, 32'h0000_0002);
        wait_read_returns("rekick", rd_returns + 1);
        if (rd_accepts != first_read + 1) begin
            report_failure("rekick", "the kick after an unmapped write did not start one read");
        end
        expected = line_pattern(addr);
        csr_rd(ADDR_LINE_FIRST, got);
        if (got !== expected[511:480]) begin
            report_mismatch("rekick", dram_line_t'(expected[511:480]), dram_line_t'(got));
        end
        finish_test("rekick", first_error);
    endtask

    initial begin
        reset             = 1'b1;
        csr_address       = '0;
        csr_writedata     = '0;
        csr_write         = 1'b0;
        csr_read          = 1'b0;
        recv_fifo_counter = '0;
        src_counter       = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        test_version_and_unmapped();
        test_control_and_counters();
        test_dram_write();
        test_dram_read();
        test_rekick();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
